// File: Bender.yml
package:
  name: sprite_renderer

export_include_dirs:
  - src

sources:
  - src/sprite_pkg.sv
  - src/raster_if.sv
  - src/sprite_store.sv
  - src/sprite_frame_fetch.sv
  - src/anim_sequencer.sv
  - src/raster_scan.sv
  - src/sprite_draw.sv
  - src/sprite_top.sv
  - target: simulation
    files:
      - verification/sprite_top_sva.sv
      - verification/tb_sprite_top.sv

// File: all.f
+incdir+src
src/sprite_pkg.sv
src/raster_if.sv
src/sprite_store.sv
src/sprite_frame_fetch.sv
src/anim_sequencer.sv
src/raster_scan.sv
src/sprite_draw.sv
src/sprite_top.sv
verification/sprite_top_sva.sv
verification/tb_sprite_top.sv

// File: src/anim_sequencer.sv
/*
 * turns movement inputs into the sprite control word once per screen
 * frame_end_i pulses with the last pixel of a screen
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

module anim_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      move_left_i,
    input  logic                      move_right_i,
    input  logic                      jump_i,
    input  logic                      frame_end_i,
    output sprite_pkg::sprite_ctrl_t  ctrl_o
);

    localparam int DIV_W = $clog2(`ANIM_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             running;

    assign running = move_left_i || move_right_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_o.facing_right <= 1'b1;
            ctrl_o.airborne     <= 1'b0;
            ctrl_o.idle         <= 1'b1;
            ctrl_o.run_frame    <= '0;
            div_cnt             <= '0;
        end else if (frame_end_i) begin
            if (move_left_i ^ move_right_i) begin
                ctrl_o.facing_right <= move_right_i;
            end
            ctrl_o.airborne <= jump_i;
            ctrl_o.idle     <= !running;

            if (!running) begin
                ctrl_o.run_frame <= '0;
                div_cnt          <= '0;
            end else if (!ctrl_o.idle) begin  // first running screen shows frame 0
                if (div_cnt == DIV_W'(`ANIM_DIV - 1)) begin
                    div_cnt <= '0;
                    if (ctrl_o.run_frame == 4'(`RUN_FRAMES - 1)) begin
                        ctrl_o.run_frame <= '0;
                    end else begin
                        ctrl_o.run_frame <= ctrl_o.run_frame + 4'd1;
                    end
                end else begin
                    div_cnt <= div_cnt + DIV_W'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/raster_if.sv
/*
 * scanned pixel coordinates, driven by the scanner and read by the draw stage
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

interface raster_if;

    logic                          valid;
    logic [$clog2(`SCREEN_W)-1:0]  x;
    logic [$clog2(`SCREEN_H)-1:0]  y;
    logic                          last;  // final pixel of the screen

    modport scan (output valid, x, y, last);
    modport draw (input valid, x, y, last);

endinterface

`default_nettype wire

// File: src/raster_scan.sv
/*
 * walks the screen in raster order, one pixel per available credit
 * the sink returns a credit for every pixel it has consumed
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

module raster_scan (
    input  logic  clk,
    input  logic  rst,
    input  logic  render_en_i,
    input  logic  credit_return_i,
    raster_if.scan scan
);

    localparam int XW = $clog2(`SCREEN_W);
    localparam int YW = $clog2(`SCREEN_H);
    localparam int CW = $clog2(`CREDITS + 1);

    logic [CW-1:0] credit_cnt;
    logic [XW-1:0] x_q;
    logic [YW-1:0] y_q;
    logic          issue;
    logic          at_eol;
    logic          at_eof;

    assign issue  = render_en_i && (credit_cnt != '0);
    assign at_eol = (x_q == XW'(`SCREEN_W - 1));
    assign at_eof = (y_q == YW'(`SCREEN_H - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CW'(`CREDITS);
        end else if (issue && !credit_return_i) begin
            credit_cnt <= credit_cnt - CW'(1);
        end else if (!issue && credit_return_i) begin
            credit_cnt <= credit_cnt + CW'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x_q <= '0;
            y_q <= '0;
        end else if (issue) begin
            if (at_eol) begin
                x_q <= '0;
                y_q <= at_eof ? '0 : y_q + YW'(1);
            end else begin
                x_q <= x_q + XW'(1);
            end
        end
    end

    // stalls on the current x/y while out of credit
    assign scan.valid = issue;
    assign scan.x     = x_q;
    assign scan.y     = y_q;
    assign scan.last  = at_eol && at_eof;

endmodule

`default_nettype wire

// File: src/sprite_draw.sv
/*
 * hit test against the sprite rectangle, sprite address and transparency key
 * tags ride two stages beside the fetch, the output pixel is registered
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

module sprite_draw (
    input  logic                                clk,
    input  logic                                rst,
    raster_if.draw                              draw,
    input  logic [$clog2(`SCREEN_W)-1:0]        sprite_x_i,
    input  logic [$clog2(`SCREEN_H)-1:0]        sprite_y_i,
    input  sprite_pkg::sprite_ctrl_t            ctrl_i,
    output logic [`PIX_ADDR_W-1:0]              pix_addr_o,
    output sprite_pkg::sprite_ctrl_t            ctrl_o,
    input  sprite_pkg::rgb_t                    rgb_i,
    output logic                                pixel_valid_o,
    output logic                                pixel_last_o,
    output sprite_pkg::rgb_t                    pixel_rgb_o
);

    localparam int XW  = $clog2(`SCREEN_W);
    localparam int YW  = $clog2(`SCREEN_H);
    localparam int SXW = $clog2(`SPRITE_W);
    localparam int SYW = $clog2(`SPRITE_H);

    logic [XW:0] dx;
    logic [YW:0] dy;
    logic        hit;
    logic        valid_q1, hit_q1, last_q1;
    logic        valid_q2, hit_q2, last_q2;

    // msb set means the pixel is left of or above the sprite
    assign dx  = {1'b0, draw.x} - {1'b0, sprite_x_i};
    assign dy  = {1'b0, draw.y} - {1'b0, sprite_y_i};
    assign hit = !dx[XW] && (dx < (XW + 1)'(`SPRITE_W))
              && !dy[YW] && (dy < (YW + 1)'(`SPRITE_H));

    // row-major, read in the issue cycle
    assign pix_addr_o = {dy[SYW-1:0], dx[SXW-1:0]};
    assign ctrl_o     = ctrl_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q1 <= 1'b0;
            last_q1  <= 1'b0;
            valid_q2 <= 1'b0;
            last_q2  <= 1'b0;
        end else begin
            valid_q1 <= draw.valid;
            last_q1  <= draw.valid && draw.last;
            valid_q2 <= valid_q1;
            last_q2  <= last_q1;
        end
        hit_q1 <= hit;
        hit_q2 <= hit_q1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_valid_o <= 1'b0;
            pixel_last_o  <= 1'b0;
        end else begin
            pixel_valid_o <= valid_q2;
            pixel_last_o  <= last_q2;
        end
        if (hit_q2 && (rgb_i != sprite_pkg::rgb_t'(`KEY_RGB))) begin
            pixel_rgb_o <= rgb_i;
        end else begin
            pixel_rgb_o <= sprite_pkg::rgb_t'(`BG_RGB);  // outside or keyed
        end
    end

endmodule

`default_nettype wire

// File: src/sprite_frame_fetch.sv
/*
 * picks the frame for the movement state and returns the sprite colour
 * two clocks from pixel address to registered colour
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

module sprite_frame_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  sprite_pkg::sprite_ctrl_t  ctrl_i,
    input  logic [`PIX_ADDR_W-1:0]    pix_addr_i,
    output logic [`STORE_ADDR_W-1:0]  store_addr_o,
    input  sprite_pkg::rgb_t          store_data_i,
    output sprite_pkg::rgb_t          rgb_o
);

    localparam int FRAME_W   = `STORE_ADDR_W - `PIX_ADDR_W;
    localparam int LEFT_BASE = `FRAME_NUM / 2;

    logic [FRAME_W-1:0] base;
    logic [FRAME_W-1:0] frame;

    always_comb begin
        base = ctrl_i.facing_right ? '0 : FRAME_W'(LEFT_BASE);
        if (ctrl_i.airborne) begin
            frame = base + FRAME_W'(1);  // jump pose is the first run frame
        end else if (ctrl_i.idle) begin
            frame = base;
        end else if (ctrl_i.run_frame < 4'(`RUN_FRAMES)) begin
            frame = base + FRAME_W'(1) + FRAME_W'(ctrl_i.run_frame);
        end else begin
            frame = base + FRAME_W'(1);
        end
    end

    assign store_addr_o = {frame, pix_addr_i};

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_o <= '0;
        end else begin
            rgb_o <= store_data_i;
        end
    end

endmodule

`default_nettype wire

// File: src/sprite_macros.svh
/*
 * sizes and constants shared by the sprite renderer
 * include this header wherever one of the macros is needed
 */
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

`define SCREEN_W      64
`define SCREEN_H      48

`define SPRITE_W      16
`define SPRITE_H      16
`define PIX_ADDR_W    8        // one frame is 16x16 words

`define FRAME_NUM     18       // 9 right, 9 left
`define STORE_ADDR_W  13       // {frame, pixel}
`define RUN_FRAMES    8
`define ANIM_DIV      2        // screens per run step

`define CREDITS       4        // downstream pixel slots

`define KEY_RGB       12'hF0F  // transparent
`define BG_RGB        12'h000

`endif

// File: src/sprite_pkg.sv
/*
 * colour and animation-control types of the sprite renderer
 * referenced by scoped name from the modules that need them
 */
`default_nettype none

package sprite_pkg;

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // movement state word, one per screen
    typedef struct packed {
        logic       facing_right;
        logic       airborne;
        logic       idle;
        logic [3:0] run_frame;
    } sprite_ctrl_t;

endpackage

`default_nettype wire

// File: src/sprite_store.sv
/*
 * sprite image memory, written by the host, read by the frame fetcher
 * read data appears one clock after the address
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

module sprite_store (
    input  logic                      clk,
    input  logic                      wr_en_i,
    input  logic [`STORE_ADDR_W-1:0]  wr_addr_i,
    input  sprite_pkg::rgb_t          wr_data_i,
    input  logic [`STORE_ADDR_W-1:0]  rd_addr_i,
    output sprite_pkg::rgb_t          rd_data_o
);

    localparam int DEPTH = `FRAME_NUM * (1 << `PIX_ADDR_W);

    sprite_pkg::rgb_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];  // block RAM read
    end

endmodule

`default_nettype wire

// File: src/sprite_top.sv
/*
 * sprite renderer top level, pixels leave under credit flow control
 * the host loads sprite frames through the load port while rendering is off
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

module sprite_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          render_en_i,
    input  logic                          credit_return_i,
    input  logic                          move_left_i,
    input  logic                          move_right_i,
    input  logic                          jump_i,
    input  logic [$clog2(`SCREEN_W)-1:0]  sprite_x_i,
    input  logic [$clog2(`SCREEN_H)-1:0]  sprite_y_i,
    input  logic                          load_valid_i,
    input  logic [`STORE_ADDR_W-1:0]      load_addr_i,
    input  sprite_pkg::rgb_t              load_data_i,
    output logic                          pixel_valid_o,
    output logic                          pixel_last_o,
    output sprite_pkg::rgb_t              pixel_rgb_o
);

    sprite_pkg::sprite_ctrl_t     seq_ctrl;
    sprite_pkg::sprite_ctrl_t     fetch_ctrl;
    logic [`PIX_ADDR_W-1:0]       pix_addr;
    logic [`STORE_ADDR_W-1:0]     store_addr;
    sprite_pkg::rgb_t             store_data;
    sprite_pkg::rgb_t             fetch_rgb;

    raster_if raster_bus ();

    raster_scan raster_scan_i (
        .clk             (clk),
        .rst             (rst),
        .render_en_i     (render_en_i),
        .credit_return_i (credit_return_i),
        .scan            (raster_bus.scan)
    );

    anim_sequencer anim_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .move_left_i  (move_left_i),
        .move_right_i (move_right_i),
        .jump_i       (jump_i),
        .frame_end_i  (raster_bus.valid && raster_bus.last),
        .ctrl_o       (seq_ctrl)
    );

    sprite_draw sprite_draw_i (
        .clk           (clk),
        .rst           (rst),
        .draw          (raster_bus.draw),
        .sprite_x_i    (sprite_x_i),
        .sprite_y_i    (sprite_y_i),
        .ctrl_i        (seq_ctrl),
        .pix_addr_o    (pix_addr),
        .ctrl_o        (fetch_ctrl),
        .rgb_i         (fetch_rgb),
        .pixel_valid_o (pixel_valid_o),
        .pixel_last_o  (pixel_last_o),
        .pixel_rgb_o   (pixel_rgb_o)
    );

    sprite_frame_fetch sprite_frame_fetch_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl_i       (fetch_ctrl),
        .pix_addr_i   (pix_addr),
        .store_addr_o (store_addr),
        .store_data_i (store_data),
        .rgb_o        (fetch_rgb)
    );

    sprite_store sprite_store_i (
        .clk       (clk),
        .wr_en_i   (load_valid_i),
        .wr_addr_i (load_addr_i),
        .wr_data_i (load_data_i),
        .rd_addr_i (store_addr),
        .rd_data_o (store_data)
    );

endmodule

`default_nettype wire

// File: verification/sprite_top_sva.sv
/*
 * assertions on the credit counter and the output stream, bound into sprite_top
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

module sprite_top_sva (
    input logic                             clk,
    input logic                             rst,
    input logic                             issue_i,
    input logic [$clog2(`CREDITS + 1)-1:0]  credit_cnt_i,
    input logic                             pixel_valid_i,
    input logic                             pixel_last_i
);

    // draw stage, fetch and output register
    a_issue_to_valid: assert property (@(posedge clk) disable iff (rst)
        issue_i |-> ##3 pixel_valid_i)
        else $error("issued pixel did not leave after 3 cycles");

    a_valid_from_issue: assert property (@(posedge clk) disable iff (rst)
        pixel_valid_i |-> $past(issue_i, 3))
        else $error("output pixel without an issue 3 cycles earlier");

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt_i <= `CREDITS)
        else $error("credit count above the downstream slots");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !pixel_valid_i && !pixel_last_i)
        else $error("output stream active after reset");

endmodule

bind sprite_top sprite_top_sva sprite_top_sva_i (
    .clk           (clk),
    .rst           (rst),
    .issue_i       (raster_bus.valid),
    .credit_cnt_i  (raster_scan_i.credit_cnt),
    .pixel_valid_i (pixel_valid_o),
    .pixel_last_i  (pixel_last_o)
);

`default_nettype wire

// File: verification/tb_sprite_top.sv
/*
 * testbench for the sprite renderer with random frames, random movement,
 * a credit-returning sink and a pixel-by-pixel reference model
 */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_macros.svh"

module tb_sprite_top;

    localparam int WORDS   = `FRAME_NUM * `SPRITE_W * `SPRITE_H;
    localparam int SCREENS = 8;
    localparam int LIMIT   = 16 * SCREENS * `SCREEN_W * `SCREEN_H + WORDS + 16;

    logic                          clk = 1'b0;
    logic                          rst, render_en_i, credit_return_i;
    logic                          move_left_i, move_right_i, jump_i;
    logic [$clog2(`SCREEN_W)-1:0]  sprite_x_i;
    logic [$clog2(`SCREEN_H)-1:0]  sprite_y_i;
    logic                          load_valid_i;
    logic [`STORE_ADDR_W-1:0]      load_addr_i;
    sprite_pkg::rgb_t              load_data_i, pixel_rgb_o;
    logic                          pixel_valid_o, pixel_last_o;

    sprite_pkg::rgb_t img [WORDS];  // copy of the store
    logic       m_right = 1'b1;      // animation model, reset state
    logic       m_air   = 1'b0;
    logic       m_idle  = 1'b1;
    logic [3:0] m_run   = '0;
    int         m_div   = 0;
    int         ex = 0, ey = 0;      // next expected pixel
    int         received = 0, returned = 0, owed = 0, hold = 0;
    int         screens = 0, errors = 0, cycles = 0;
    logic       new_screen = 1'b0;

    sprite_top sprite_top_i (.*);

    always #4 clk = ~clk;

    // 9 frames per facing, idle first
    function automatic int frame_of();
        int base;
        base = m_right ? 0 : `FRAME_NUM / 2;
        if (m_air)
            return base + 1;
        if (m_idle)
            return base;
        if (m_run < `RUN_FRAMES)
            return base + 1 + m_run;
        return base + 1;
    endfunction

    function automatic sprite_pkg::rgb_t expect_rgb(int x, int y);
        int sx, sy, addr;
        sx = sprite_x_i;
        sy = sprite_y_i;
        if (x < sx || x >= sx + `SPRITE_W || y < sy || y >= sy + `SPRITE_H)
            return `BG_RGB;
        addr = frame_of() * `SPRITE_W * `SPRITE_H + (y - sy) * `SPRITE_W + (x - sx);
        if (img[addr] == `KEY_RGB)
            return `BG_RGB;
        return img[addr];
    endfunction

    // moves sampled at each screen end
    task automatic step_anim();
        logic running;
        running = move_left_i || move_right_i;
        if (move_left_i ^ move_right_i)
            m_right = move_right_i;
        m_air = jump_i;
        if (!running) begin
            m_run = '0;
            m_div = 0;
        end else if (!m_idle) begin
            if (m_div == `ANIM_DIV - 1) begin
                m_div = 0;
                m_run = (m_run + 1) % `RUN_FRAMES;
            end else begin
                m_div++;
            end
        end
        m_idle = !running;
    endtask

    always @(negedge clk) begin : monitor
        sprite_pkg::rgb_t exp_rgb;
        logic             exp_last;
        if (rst) begin
            if (pixel_valid_o !== 1'b0 || pixel_last_o !== 1'b0) begin
                errors++;
                $display("[FAIL] %0t: pixel stream active during reset", $time);
            end
        end else if (pixel_valid_o && screens < SCREENS) begin
            exp_rgb  = expect_rgb(ex, ey);
            exp_last = (ex == `SCREEN_W - 1) && (ey == `SCREEN_H - 1);
            if (pixel_rgb_o !== exp_rgb) begin
                errors++;
                $display("[FAIL] %0t: screen %0d pixel (%0d,%0d) rgb %h, expected %h",
                         $time, screens, ex, ey, pixel_rgb_o, exp_rgb);
            end
            if (pixel_last_o !== exp_last) begin
                errors++;
                $display("[FAIL] %0t: screen %0d pixel (%0d,%0d) last %b, expected %b",
                         $time, screens, ex, ey, pixel_last_o, exp_last);
            end
            received++;
            owed++;
            if (received - returned > `CREDITS) begin
                errors++;
                $display("[FAIL] %0t: %0d pixels received against %0d credits returned",
                         $time, received, returned);
            end
            if (exp_last) begin
                ex = 0;
                ey = 0;
                step_anim();
                screens++;
                new_screen = 1'b1;
            end else if (ex == `SCREEN_W - 1) begin
                ex = 0;
                ey++;
            end else begin
                ex++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d screens received",
                     cycles, screens, SCREENS);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin : stimulus
        logic [11:0] word;
        void'($urandom(23960));
        rst             = 1'b1;
        render_en_i     = 1'b0;
        credit_return_i = 1'b0;
        move_left_i     = 1'b0;
        move_right_i    = 1'b0;
        jump_i          = 1'b0;
        sprite_x_i      = '0;
        sprite_y_i      = '0;
        load_valid_i    = 1'b0;
        load_addr_i     = '0;
        load_data_i     = '0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        for (int i = 0; i < WORDS; i++) begin
            word = ($urandom % 4 == 0) ? 12'(`KEY_RGB) : 12'($urandom);
            img[i]       = word;
            load_valid_i = 1'b1;
            load_addr_i  = i;
            load_data_i  = word;
            @(posedge clk);
            #1;
        end
        load_valid_i = 1'b0;

        sprite_x_i   = $urandom_range(`SCREEN_W - `SPRITE_W / 2);
        sprite_y_i   = $urandom_range(`SCREEN_H - `SPRITE_H / 2);
        move_left_i  = $urandom % 2;
        move_right_i = $urandom % 2;
        jump_i       = ($urandom % 4 == 0);
        render_en_i  = 1'b1;

        // sink returns one credit per consumed pixel, with random gaps
        while (screens < SCREENS) begin
            if (new_screen) begin
                new_screen   = 1'b0;
                move_left_i  = $urandom % 2;
                move_right_i = $urandom % 2;
                jump_i       = ($urandom % 4 == 0);
            end
            credit_return_i = 1'b0;
            if (hold > 0) begin
                hold--;
            end else if ($urandom % 256 == 0) begin
                hold = 8 + $urandom % 32;  // back-pressure burst
            end else if (owed > 0 && $urandom % 3 != 0) begin
                credit_return_i = 1'b1;
                owed--;
                returned++;
            end
            @(posedge clk);
            #1;
        end

        $display("screens %0d, pixels %0d, credits returned %0d, errors %0d",
                 screens, received, returned, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
